/* rtl/lsu_pkg.sv */
// Shared widths, access-type and state enums, and counter constants of the LSU
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data path types
  //////////////////////////////////////////////////////////////////////

  // Data or address word
  typedef logic [31:0] word_t;

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Byte offset inside a word
  typedef logic [1:0] offset_t;

  // Access size in the core decoder's encoding
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // Request control FSM
  typedef enum logic [2:0] {
    IDLE,
    REQ_FIRST,
    WAIT_FIRST,
    REQ_SECOND,
    WAIT_SECOND
  } lsu_state_e;

  //////////////////////////////////////////////////////////////////////
  // Performance counters
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CNT_W = 16;

  typedef logic [CNT_W-1:0] cnt_t;

  localparam cnt_t CNT_MAX = {CNT_W{1'b1}};

endpackage

/* rtl/lsu_ifs.sv */
// Read-data strobe interface and performance event interface with their modports

// Strobes from request control to the load data path
interface lsu_rdata_if import lsu_pkg::*; ();
  logic       capture_first;
  logic       finish;
  offset_t    offset;
  data_type_e data_type;
  logic       sign_ext;

  modport ctrl (output capture_first, finish, offset, data_type, sign_ext);
  modport dp   (input  capture_first, finish, offset, data_type, sign_ext);
endinterface

// Single-cycle events for the memory counters
interface lsu_perf_if ();
  logic load_gnt;
  logic store_gnt;
  logic split_start;
  logic bus_err;

  modport src  (output load_gnt, store_gnt, split_start, bus_err);
  modport sink (input  load_gnt, store_gnt, split_start, bus_err);
endinterface

/* rtl/lsu_ctrl.sv */
// Request FSM, misaligned split, byte enables, write data rotation and completion
module lsu_ctrl import lsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Command from the execute side
  input  logic       lsu_req_i,
  input  logic       lsu_we_i,
  input  data_type_e lsu_type_i,
  input  logic       lsu_sign_ext_i,
  input  word_t      lsu_addr_i,
  input  word_t      lsu_wdata_i,

  // Data memory handshake
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  logic       data_err_i,
  output logic       data_req_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_addr_o,
  output word_t      data_wdata_o,

  // Completion
  output logic       lsu_valid_o,
  output logic       lsu_busy_o,
  output logic       load_err_o,
  output logic       store_err_o,

  lsu_rdata_if.ctrl  rd,
  lsu_perf_if.src    perf
);

  lsu_state_e  state_q, state_d;

  // Latched command
  logic        we_q;
  logic        sign_ext_q;
  data_type_e  type_q;
  word_t       addr_q;
  word_t       wdata_q;

  logic        accept;
  logic        split;
  logic        final_rvalid;
  offset_t     offset;
  be_t         be_base;
  logic [7:0]  be_wide;
  logic [63:0] wdata_dbl;
  word_t       addr_aligned;

  assign accept = lsu_req_i & (state_q == IDLE);
  assign offset = addr_q[1:0];

  // Word not on a word boundary, or half crossing into the next word
  assign split = ((type_q == DT_WORD) && (offset != 2'b00)) ||
                 ((type_q == DT_HALF) && (offset == 2'b11));

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q       <= lsu_we_i;
      sign_ext_q <= lsu_sign_ext_i;
      type_q     <= lsu_type_i;
      addr_q     <= lsu_addr_i;
      wdata_q    <= lsu_wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:        if (accept) state_d = REQ_FIRST;
      REQ_FIRST:   if (data_gnt_i) state_d = WAIT_FIRST;
      // An error on the first part ends the access
      WAIT_FIRST:  if (data_rvalid_i) state_d = (split && !data_err_i) ? REQ_SECOND : IDLE;
      REQ_SECOND:  if (data_gnt_i) state_d = WAIT_SECOND;
      WAIT_SECOND: if (data_rvalid_i) state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus fields per part
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (type_q)
      DT_WORD: be_base = 4'b1111;
      DT_HALF: be_base = 4'b0011;
      default: be_base = 4'b0001;
    endcase
  end

  // Upper nibble holds the lanes that spill into the next word
  assign be_wide      = {4'b0000, be_base} << offset;
  assign wdata_dbl    = {wdata_q, wdata_q} << {offset, 3'b000};
  assign addr_aligned = {addr_q[31:2], 2'b00};

  assign data_req_o   = (state_q == REQ_FIRST) || (state_q == REQ_SECOND);
  assign data_we_o    = we_q;
  assign data_be_o    = (state_q == REQ_SECOND) ? be_wide[7:4] : be_wide[3:0];
  assign data_addr_o  = (state_q == REQ_SECOND) ? addr_aligned + 32'd4 : addr_aligned;
  assign data_wdata_o = wdata_dbl[63:32];

  //////////////////////////////////////////////////////////////////////
  // Completion, strobes and events
  //////////////////////////////////////////////////////////////////////

  assign final_rvalid = data_rvalid_i &
                        (((state_q == WAIT_FIRST) & (~split | data_err_i)) |
                         (state_q == WAIT_SECOND));

  assign lsu_valid_o = final_rvalid;
  assign lsu_busy_o  = (state_q != IDLE);
  assign load_err_o  = final_rvalid & data_err_i & ~we_q;
  assign store_err_o = final_rvalid & data_err_i & we_q;

  assign rd.capture_first = data_rvalid_i & (state_q == WAIT_FIRST) & split &
                            ~data_err_i & ~we_q;
  assign rd.finish        = final_rvalid & ~we_q;
  assign rd.offset        = offset;
  assign rd.data_type     = type_q;
  assign rd.sign_ext      = sign_ext_q;

  assign perf.load_gnt    = data_req_o & data_gnt_i & ~we_q;
  assign perf.store_gnt   = data_req_o & data_gnt_i & we_q;
  assign perf.split_start = (state_q == REQ_FIRST) & data_gnt_i & split;
  assign perf.bus_err     = data_rvalid_i & data_err_i &
                            ((state_q == WAIT_FIRST) | (state_q == WAIT_SECOND));

endmodule

/* rtl/lsu_rdata.sv */
// Load data path with first-part capture, byte reassembly and extension
module lsu_rdata import lsu_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,

  input  word_t  data_rdata_i,
  lsu_rdata_if.dp rd,

  output word_t  lsu_rdata_o
);

  word_t       first_q;
  logic        have_first_q;
  word_t       lower;
  logic [63:0] merged;
  word_t       aligned;

  // First word of a split load
  always_ff @(posedge clk_i) begin
    if (rd.capture_first) begin
      first_q <= data_rdata_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      have_first_q <= 1'b0;
    end else if (rd.finish) begin
      have_first_q <= 1'b0;
    end else if (rd.capture_first) begin
      have_first_q <= 1'b1;
    end
  end

  // Without a captured part both halves come from the current word
  assign lower   = have_first_q ? first_q : data_rdata_i;
  assign merged  = {data_rdata_i, lower} >> {rd.offset, 3'b000};
  assign aligned = merged[31:0];

  // Size selection and extension
  always_comb begin
    unique case (rd.data_type)
      DT_WORD: lsu_rdata_o = aligned;
      DT_HALF: lsu_rdata_o = {{16{rd.sign_ext & aligned[15]}}, aligned[15:0]};
      default: lsu_rdata_o = {{24{rd.sign_ext & aligned[7]}}, aligned[7:0]};
    endcase
  end

endmodule

/* rtl/lsu_perf_counters.sv */
// Saturating memory performance counters for loads, stores, splits and bus errors
module lsu_perf_counters import lsu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,

  lsu_perf_if.sink perf,

  output cnt_t    perf_load_o,
  output cnt_t    perf_store_o,
  output cnt_t    perf_split_o,
  output cnt_t    perf_err_o
);

  logic [3:0] event_vec;
  cnt_t       cnt_q [4];

  // Bit order matches the output order
  assign event_vec = {perf.bus_err, perf.split_start, perf.store_gnt, perf.load_gnt};

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        // Hold at the top value
        if (event_vec[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end
      end
    end
  end

  assign perf_load_o  = cnt_q[0];
  assign perf_store_o = cnt_q[1];
  assign perf_split_o = cnt_q[2];
  assign perf_err_o   = cnt_q[3];

endmodule

/* rtl/lsu_top.sv */
// LSU top level connecting request control, load data path and counters
module lsu_top import lsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Command side
  input  logic       lsu_req_i,
  input  logic       lsu_we_i,
  input  data_type_e lsu_type_i,
  input  logic       lsu_sign_ext_i,
  input  word_t      lsu_addr_i,
  input  word_t      lsu_wdata_i,
  output logic       lsu_valid_o,
  output word_t      lsu_rdata_o,
  output logic       lsu_busy_o,
  output logic       load_err_o,
  output logic       store_err_o,

  // Data memory bus
  output logic       data_req_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  logic       data_err_i,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_addr_o,
  output word_t      data_wdata_o,
  input  word_t      data_rdata_i,

  // Memory counters
  output cnt_t       perf_load_o,
  output cnt_t       perf_store_o,
  output cnt_t       perf_split_o,
  output cnt_t       perf_err_o
);

  lsu_rdata_if rd_if ();
  lsu_perf_if  perf_if ();

  lsu_ctrl u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .lsu_req_i      ( lsu_req_i      ),
    .lsu_we_i       ( lsu_we_i       ),
    .lsu_type_i     ( lsu_type_i     ),
    .lsu_sign_ext_i ( lsu_sign_ext_i ),
    .lsu_addr_i     ( lsu_addr_i     ),
    .lsu_wdata_i    ( lsu_wdata_i    ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_err_i     ( data_err_i     ),
    .data_req_o     ( data_req_o     ),
    .data_we_o      ( data_we_o      ),
    .data_be_o      ( data_be_o      ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .lsu_valid_o    ( lsu_valid_o    ),
    .lsu_busy_o     ( lsu_busy_o     ),
    .load_err_o     ( load_err_o     ),
    .store_err_o    ( store_err_o    ),
    .rd             ( rd_if.ctrl     ),
    .perf           ( perf_if.src    )
  );

  lsu_rdata u_rdata (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .data_rdata_i ( data_rdata_i ),
    .rd           ( rd_if.dp     ),
    .lsu_rdata_o  ( lsu_rdata_o  )
  );

  lsu_perf_counters u_perf (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .perf         ( perf_if.sink ),
    .perf_load_o  ( perf_load_o  ),
    .perf_store_o ( perf_store_o ),
    .perf_split_o ( perf_split_o ),
    .perf_err_o   ( perf_err_o   )
  );

endmodule

/* tests/lsu_properties.sv */
// Bus and command handshake assertions bound to the LSU top level
module lsu_properties import lsu_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  data_req_o,
  input logic  data_gnt_i,
  input logic  data_we_o,
  input be_t   data_be_o,
  input word_t data_addr_o,
  input word_t data_wdata_o,
  input logic  lsu_valid_o,
  input logic  lsu_busy_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Request and its fields hold until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_be_o) && $stable(data_we_o) && $stable(data_wdata_o))
    else $error("data_req_o or its fields changed before the grant");

  valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_o |=> !lsu_valid_o)
    else $error("lsu_valid_o held longer than one cycle");

  reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !data_req_o && !lsu_busy_o && !lsu_valid_o)
    else $error("LSU not idle when reset is released");

endmodule

bind lsu_top lsu_properties u_props (.*);

/* tests/tb_lsu.sv */
// LSU testbench with clock, reset, memory responder, watchdog and directed tests
module tb_lsu import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic       clk_i, rst_ni;
  logic       lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  data_type_e lsu_type_i;
  word_t      lsu_addr_i, lsu_wdata_i, lsu_rdata_o;
  logic       lsu_valid_o, lsu_busy_o, load_err_o, store_err_o;
  logic       data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  be_t        data_be_o;
  word_t      data_addr_o, data_wdata_o, data_rdata_i;
  cnt_t       perf_load_o, perf_store_o, perf_split_o, perf_err_o;

  word_t      mem [64];
  logic [7:0] exp_mem [256];
  cnt_t       cnt_load, cnt_store, cnt_split, cnt_err;
  int         errors;
  int         n_issued;
  int         n_trans;

  lsu_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Model helpers
  //////////////////////////////////////////////////////////////////////

  function automatic word_t fill_word(input int w);
    return word_t'(w + 1) * 32'h9e3779b1;
  endfunction

  function automatic int bytes_of(input data_type_e t);
    case (t)
      DT_WORD: return 4;
      DT_HALF: return 2;
      default: return 1;
    endcase
  endfunction

  function automatic logic is_split(input data_type_e t, input word_t a);
    return ((t == DT_WORD) && (a[1:0] != 2'b00)) || ((t == DT_HALF) && (a[1:0] == 2'b11));
  endfunction

  // Byte i from address plus i, then extension
  function automatic word_t expected_load(input data_type_e t, input logic sext, input word_t a);
    word_t v;
    v = '0;
    for (int i = 0; i < bytes_of(t); i++) v[8*i +: 8] = exp_mem[a[7:0] + 8'(i)];
    if (sext && (t == DT_BYTE)) v[31:8] = {24{v[7]}};
    if (sext && (t == DT_HALF)) v[31:16] = {16{v[15]}};
    return v;
  endfunction

  task automatic report_mismatch(input string name, input word_t exp_v, input word_t act_v);
    errors++;
    $display("Fail at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  task automatic compare_memory();
    word_t exp_w;
    for (int w = 0; w < 64; w++) begin
      for (int b = 0; b < 4; b++) exp_w[8*b +: 8] = exp_mem[8'(4*w + b)];
      if (mem[6'(w)] !== exp_w) report_mismatch($sformatf("mem[%0d]", w), exp_w, mem[6'(w)]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory responder with random grant and rvalid delays
  //////////////////////////////////////////////////////////////////////

  initial begin : responder
    int    dly;
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    for (int w = 0; w < 64; w++) mem[6'(w)] = fill_word(w);
    forever begin
      @(negedge clk_i);
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
      if (rst_ni && data_req_o) begin
        dly = int'($urandom % 4);
        repeat (dly) begin
          @(negedge clk_i);
          if (!data_req_o) begin
            errors++;
            $display("Error at %0t: data_req_o dropped before its grant", $time);
          end
        end
        data_gnt_i = 1'b1;
        addr  = data_addr_o;
        we    = data_we_o;
        be    = data_be_o;
        wdata = data_wdata_o;
        n_trans++;
        @(negedge clk_i);
        data_gnt_i = 1'b0;
        dly = int'($urandom % 4);
        repeat (dly) @(negedge clk_i);
        data_rvalid_i = 1'b1;
        // Top word answers with a bus error
        data_err_i    = (addr[7:2] == 6'd63);
        data_rdata_i  = mem[addr[7:2]];
        if (we && !data_err_i) begin
          for (int b = 0; b < 4; b++) if (be[b]) mem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * (n_issued + 1)) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d commands issued", cycles, n_issued);
    $display(">>> FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Command driver and checks
  //////////////////////////////////////////////////////////////////////

  task automatic issue_access(input logic we, input data_type_e t, input logic sext,
                              input word_t a, input word_t wd);
    logic  exp_err;
    int    exp_trans;
    word_t exp_rd;
    exp_err   = (a[7:2] == 6'd63);
    exp_trans = (is_split(t, a) && !exp_err) ? 2 : 1;
    exp_rd    = expected_load(t, sext, a);
    @(negedge clk_i);
    lsu_req_i      = 1'b1;
    lsu_we_i       = we;
    lsu_type_i     = t;
    lsu_sign_ext_i = sext;
    lsu_addr_i     = a;
    lsu_wdata_i    = wd;
    n_trans        = 0;
    n_issued++;
    @(negedge clk_i);
    lsu_req_i = 1'b0;
    #2;
    if (lsu_busy_o !== 1'b1) report_mismatch("lsu_busy_o", 32'd1, word_t'(lsu_busy_o));
    while (!lsu_valid_o) begin
      @(negedge clk_i);
      #2;
    end
    if (load_err_o !== (exp_err & ~we))
      report_mismatch("load_err_o", word_t'(exp_err & ~we), word_t'(load_err_o));
    if (store_err_o !== (exp_err & we))
      report_mismatch("store_err_o", word_t'(exp_err & we), word_t'(store_err_o));
    if (!we && !exp_err && (lsu_rdata_o !== exp_rd))
      report_mismatch("lsu_rdata_o", exp_rd, lsu_rdata_o);
    if (n_trans != exp_trans)
      report_mismatch("bus transactions", word_t'(exp_trans), word_t'(n_trans));
    // Idle again in the cycle after completion
    @(negedge clk_i);
    #2;
    if (lsu_busy_o !== 1'b0) report_mismatch("lsu_busy_o", 32'd0, word_t'(lsu_busy_o));
    if (we && !exp_err) begin
      for (int i = 0; i < bytes_of(t); i++) exp_mem[a[7:0] + 8'(i)] = wd[8*i +: 8];
    end
    // One count per granted part
    if (we) cnt_store = cnt_store + cnt_t'(exp_trans);
    else cnt_load = cnt_load + cnt_t'(exp_trans);
    if (is_split(t, a)) cnt_split = cnt_split + cnt_t'(1);
    if (exp_err) cnt_err = cnt_err + cnt_t'(1);
  endtask

  task automatic round_trip(input data_type_e t, input word_t a, input word_t wd);
    issue_access(1'b1, t, 1'b0, a, wd);
    issue_access(1'b0, t, 1'b0, a, '0);
    issue_access(1'b0, t, 1'b1, a, '0);
  endtask

  task automatic aligned_round_trip();
    round_trip(DT_WORD, 32'h10, $urandom);
    // Sign bit set on one half and one byte, clear on the others
    round_trip(DT_HALF, 32'h22, $urandom | 32'h8000);
    round_trip(DT_HALF, 32'h24, $urandom & 32'h7fff);
    round_trip(DT_BYTE, 32'h31, $urandom | 32'h80);
    round_trip(DT_BYTE, 32'h37, $urandom & 32'h7f);
    compare_memory();
  endtask

  task automatic misaligned_split();
    for (int off = 1; off < 4; off++) round_trip(DT_WORD, 32'h40 + word_t'(9 * off), $urandom);
    round_trip(DT_HALF, 32'h63, $urandom);
    compare_memory();
  endtask

  task automatic random_traffic();
    data_type_e t;
    word_t      a;
    repeat (24) begin
      case ($urandom % 3)
        0: t = DT_WORD;
        1: t = DT_HALF;
        default: t = DT_BYTE;
      endcase
      a = (($urandom % 62) * 4) + ($urandom % 4);
      round_trip(t, a, $urandom);
    end
    compare_memory();
  endtask

  task automatic error_responses();
    issue_access(1'b0, DT_WORD, 1'b0, 32'hfc, '0);
    issue_access(1'b1, DT_BYTE, 1'b0, 32'hfe, $urandom);
    // Split accesses failing on the first part
    issue_access(1'b1, DT_WORD, 1'b0, 32'hfd, $urandom);
    issue_access(1'b0, DT_HALF, 1'b1, 32'hff, '0);
    compare_memory();
  endtask

  task automatic counter_totals();
    @(negedge clk_i);
    #2;
    if (perf_load_o !== cnt_load) report_mismatch("perf_load_o", 32'(cnt_load), 32'(perf_load_o));
    if (perf_store_o !== cnt_store)
      report_mismatch("perf_store_o", 32'(cnt_store), 32'(perf_store_o));
    if (perf_split_o !== cnt_split)
      report_mismatch("perf_split_o", 32'(cnt_split), 32'(perf_split_o));
    if (perf_err_o !== cnt_err) report_mismatch("perf_err_o", 32'(cnt_err), 32'(perf_err_o));
  endtask

  initial begin : main
    word_t w_val;
    void'($urandom(32'h3f954847));
    errors         = 0;
    n_issued       = 0;
    n_trans        = 0;
    cnt_load       = '0;
    cnt_store      = '0;
    cnt_split      = '0;
    cnt_err        = '0;
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = DT_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    for (int w = 0; w < 64; w++) begin
      w_val = fill_word(w);
      for (int b = 0; b < 4; b++) exp_mem[8'(4*w + b)] = w_val[8*b +: 8];
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    aligned_round_trip();
    misaligned_split();
    random_traffic();
    error_responses();
    counter_totals();
    $display("Errors: %0d in %0d commands", errors, n_issued);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/lsu_pkg.sv
rtl/lsu_ifs.sv
rtl/lsu_ctrl.sv
rtl/lsu_rdata.sv
rtl/lsu_perf_counters.sv
rtl/lsu_top.sv
tests/lsu_properties.sv
tests/tb_lsu.sv

/* Makefile */
# Verilator flow for the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
